// ==== tb/mlp_trace.txt ====
// gap retrigger x0 x1 x2 x3 x4 x5 x6 x7 x8 x9 expected
// gap is idle cycles before start, retrigger 01 pulses start again while busy
02 00 00 00 00 00 00 00 00 00 00 00 6e
00 00 01 00 00 00 00 00 00 00 00 00 6f
00 00 00 02 00 00 00 00 00 00 00 00 56
03 01 00 00 01 00 00 00 00 00 00 00 04
00 00 00 00 00 01 00 00 00 00 00 00 00
01 00 ff 00 01 00 00 00 00 00 00 00 6c
00 00 00 00 00 00 00 00 00 00 00 01 01
05 00 00 00 00 00 00 00 00 00 01 00 00
00 00 01 02 00 00 00 00 00 00 00 00 05
02 00 00 00 00 00 7f 00 00 00 00 00 5e

// ==== compile.f ====
logic/nnFormatPkg.sv
logic/nnWeightsPkg.sv
logic/denseNode.sv
logic/serialNode.sv
logic/stepCounter.sv
logic/layerSequencer.sv
logic/mlpCore.sv
tb/tbClock.sv
tb/resultChecker.sv
tb/mlpCore_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal -j 0
TOP = mlpCore_tb
FILELIST = compile.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/mlpCore_tb.sv ====
`timescale 1ns/100ps

module mlpCore_tb
	import nnFormatPkg::*;
();

	localparam int numTests = 10;
	// Gap, retrigger flag, ten inputs, expected.
	localparam int lineWords = 13;

	logic clk;
	logic reset;
	logic start;
	logic [dataWidth-1:0] activation [numInputs];
	logic [dataWidth-1:0] expected;
	logic busy;
	logic done;
	logic [dataWidth-1:0] result;
	logic [dataWidth-1:0] trace [0:numTests*lineWords-1];
	int mismatches;
	int otherErrors;
	int cycles;
	int timeoutLimit;

	tbClock u_clock (.clk(clk), .reset(reset));

	mlpCore #(
		.numHidden(numHidden)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.activation0(activation[0]),
		.activation1(activation[1]),
		.activation2(activation[2]),
		.activation3(activation[3]),
		.activation4(activation[4]),
		.activation5(activation[5]),
		.activation6(activation[6]),
		.activation7(activation[7]),
		.activation8(activation[8]),
		.activation9(activation[9]),
		.busy(busy),
		.done(done),
		.result(result)
	);

	resultChecker u_checker (
		.clk(clk),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.result(result),
		.expected(expected),
		.mismatches(mismatches),
		.otherErrors(otherErrors)
	);

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= timeoutLimit)
		begin
			$display("Error: the run did not finish within %0d cycles", timeoutLimit);
			$display("Mismatches: %0d, other errors: %0d", mismatches, otherErrors + 1);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Second start lands while the core is busy.
	task automatic pulseWhileBusy();
		repeat (2) @(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic runTest(input int t);
		int base;
		base = t * lineWords;
		repeat (int'(trace[base])) @(negedge clk);
		for (int i = 0; i < numInputs; i++)
			activation[i] = trace[base + 2 + i];
		expected = trace[base + 12];
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (trace[base + 1] != '0)
			pulseWhileBusy();
		while (!done)
			@(negedge clk);
	endtask

	initial
	begin
		int maxGap;
		start = 1'b0;
		expected = '0;
		for (int i = 0; i < numInputs; i++)
			activation[i] = '0;
		$readmemh("tb/mlp_trace.txt", trace);
		maxGap = 0;
		for (int t = 0; t < numTests; t++)
			if (int'(trace[t * lineWords]) > maxGap)
				maxGap = int'(trace[t * lineWords]);
		timeoutLimit = numTests * (maxGap + 12) + 50;
		@(negedge clk);
		while (reset)
			@(negedge clk);
		for (int t = 0; t < numTests; t++)
			runTest(t);
		// Quiet time to catch a stray done.
		repeat (12) @(negedge clk);
		$display("Mismatches: %0d, other errors: %0d", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== tb/resultChecker.sv ====
`timescale 1ns/100ps

module resultChecker
	import nnFormatPkg::*;
#(
	parameter int latency = 8
)(
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done,
	input logic [dataWidth-1:0] result,
	input logic [dataWidth-1:0] expected,
	output int mismatches,
	output int otherErrors
);

	int cycle;
	int startCycle;
	int acceptCount;
	int doneCount;
	logic [dataWidth-1:0] expectedValue;

	// A start only counts while the core is idle.
	always @(posedge clk)
	begin
		if (reset)
		begin
			cycle <= 0;
			startCycle <= 0;
			acceptCount <= 0;
			expectedValue <= '0;
		end
		else
		begin
			cycle <= cycle + 1;
			if (start && !busy)
			begin
				acceptCount <= acceptCount + 1;
				startCycle <= cycle + 1;
				expectedValue <= expected;
			end
		end
	end

	// Outputs are stable away from the rising edge.
	always @(negedge clk)
	begin
		int elapsed;
		if (reset)
		begin
			doneCount = 0;
			mismatches = 0;
			otherErrors = 0;
		end
		else if (acceptCount == doneCount)
		begin
			if (done)
			begin
				$display("Error at %0d ns: done pulsed with no request pending", $time);
				otherErrors = otherErrors + 1;
			end
			if (busy)
			begin
				$display("Error at %0d ns: busy high with no request pending", $time);
				otherErrors = otherErrors + 1;
			end
			if (acceptCount == 0 && result != '0)
			begin
				$display("Mismatch at %0d ns: result %h before first start, expected 00",
					$time, result);
				mismatches = mismatches + 1;
			end
		end
		else
		begin
			elapsed = cycle - startCycle;
			if (elapsed < latency)
			begin
				if (!busy || done)
				begin
					$display("Error at %0d ns: busy low or done early, %0d cycles after start",
						$time, elapsed);
					otherErrors = otherErrors + 1;
				end
			end
			else
			begin
				if (!done)
				begin
					$display("Error at %0d ns: no done %0d cycles after start", $time, latency);
					otherErrors = otherErrors + 1;
				end
				else if (result != expectedValue)
				begin
					$display("Mismatch at %0d ns: result %h, expected %h",
						$time, result, expectedValue);
					mismatches = mismatches + 1;
				end
				if (busy)
				begin
					$display("Error at %0d ns: busy still high at done", $time);
					otherErrors = otherErrors + 1;
				end
				doneCount = doneCount + 1;
			end
		end
	end

endmodule

// ==== tb/tbClock.sv ====
`timescale 1ns/100ps

module tbClock
#(
	parameter real halfPeriod = 4.0,
	parameter int resetCycles = 3
)(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Released on a falling edge, like every other input.
	initial
	begin
		reset <= 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== logic/mlpCore.sv ====
`timescale 1ns/100ps

module mlpCore
	import nnFormatPkg::*;
	import nnWeightsPkg::*;
#(
	parameter int numHidden = nnFormatPkg::numHidden
)(
	input logic clk,
	input logic reset,
	input logic start,
	input logic signed [dataWidth-1:0] activation0,
	input logic signed [dataWidth-1:0] activation1,
	input logic signed [dataWidth-1:0] activation2,
	input logic signed [dataWidth-1:0] activation3,
	input logic signed [dataWidth-1:0] activation4,
	input logic signed [dataWidth-1:0] activation5,
	input logic signed [dataWidth-1:0] activation6,
	input logic signed [dataWidth-1:0] activation7,
	input logic signed [dataWidth-1:0] activation8,
	input logic signed [dataWidth-1:0] activation9,
	output logic busy,
	output logic done,
	output logic [dataWidth-1:0] result
);

	logic [dataWidth-1:0] hidden0;
	logic [dataWidth-1:0] hidden1;
	logic [dataWidth-1:0] hidden2;
	logic [dataWidth-1:0] hidden3;
	logic [dataWidth-1:0] hiddenValue;
	countValue count;
	countValue loadValue;
	logic zero;
	logic load;
	logic enable;
	logic clear;
	logic accumulate;
	logic finish;

	// Free-running hidden layer.
	denseNode #(.weights(hiddenWeights[0]), .bias(hiddenBias[0])) u_node0 (.*, .hidden(hidden0));
	denseNode #(.weights(hiddenWeights[1]), .bias(hiddenBias[1])) u_node1 (.*, .hidden(hidden1));
	denseNode #(.weights(hiddenWeights[2]), .bias(hiddenBias[2])) u_node2 (.*, .hidden(hidden2));
	denseNode #(.weights(hiddenWeights[3]), .bias(hiddenBias[3])) u_node3 (.*, .hidden(hidden3));

	// Counter steps down from the last hidden neuron.
	always_comb
	begin
		case (count)
			countValue'(0): hiddenValue = hidden0;
			countValue'(1): hiddenValue = hidden1;
			countValue'(2): hiddenValue = hidden2;
			countValue'(3): hiddenValue = hidden3;
			default: hiddenValue = '0;
		endcase
	end

	serialNode #(
		.weights(outputWeights),
		.bias(outputBias)
	) u_outNode (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.accumulate(accumulate),
		.finish(finish),
		.index(count),
		.hiddenValue(hiddenValue),
		.result(result)
	);

	stepCounter #(
		.width($bits(countValue))
	) u_counter (
		.clk(clk),
		.reset(reset),
		.load(load),
		.loadValue(loadValue),
		.enable(enable),
		.count(count),
		.zero(zero)
	);

	layerSequencer #(
		.numHidden(numHidden),
		.settleCycles(settleCycles)
	) u_sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.zero(zero),
		.busy(busy),
		.done(done),
		.load(load),
		.loadValue(loadValue),
		.enable(enable),
		.clear(clear),
		.accumulate(accumulate),
		.finish(finish)
	);

endmodule

// ==== logic/layerSequencer.sv ====
`timescale 1ns/100ps

module layerSequencer
	import nnFormatPkg::*;
#(
	parameter int numHidden = nnFormatPkg::numHidden,
	parameter int settleCycles = nnFormatPkg::settleCycles
)(
	input logic clk,
	input logic reset,
	input logic start,
	input logic zero,
	output logic busy,
	output logic done,
	output logic load,
	output countValue loadValue,
	output logic enable,
	output logic clear,
	output logic accumulate,
	output logic finish
);

	seqState state;
	seqState nextState;

	assign busy = (state != seqIdle);

	always_comb
	begin
		nextState = state;
		load = 1'b0;
		loadValue = '0;
		enable = 1'b0;
		clear = 1'b0;
		accumulate = 1'b0;
		finish = 1'b0;
		case (state)
			seqIdle:
			begin
				if (start)
				begin
					nextState = seqSettle;
					load = 1'b1;
					loadValue = countValue'(settleCycles - 1);
					clear = 1'b1;
				end
			end
			seqSettle:
			begin
				// Hidden values are valid once the wait runs out.
				if (zero)
				begin
					nextState = seqAccumulate;
					load = 1'b1;
					loadValue = countValue'(numHidden - 1);
				end
				else
					enable = 1'b1;
			end
			seqAccumulate:
			begin
				accumulate = 1'b1;
				if (zero)
					nextState = seqFinish;
				else
					enable = 1'b1;
			end
			seqFinish:
			begin
				finish = 1'b1;
				nextState = seqIdle;
			end
			default:
				nextState = seqIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= seqIdle;
			done <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// Lines up with the result register update.
			done <= (state == seqFinish);
		end
	end

endmodule

// ==== logic/stepCounter.sv ====
`timescale 1ns/100ps

module stepCounter
	import nnFormatPkg::*;
#(
	parameter int width = $bits(countValue)
)(
	input logic clk,
	input logic reset,
	input logic load,
	input logic [width-1:0] loadValue,
	input logic enable,
	output logic [width-1:0] count,
	output logic zero
);

	assign zero = (count == '0);

	// Holds at zero.
	always_ff @(posedge clk)
	begin
		if (reset)
			count <= '0;
		else if (load)
			count <= loadValue;
		else if (enable && !zero)
			count <= count - 1'b1;
	end

endmodule

// ==== logic/serialNode.sv ====
`timescale 1ns/100ps

module serialNode
	import nnFormatPkg::*;
#(
	parameter logic [0:numHidden-1][dataWidth-1:0] weights = '0,
	parameter logic [dataWidth-1:0] bias = '0
)(
	input logic clk,
	input logic reset,
	input logic clear,
	input logic accumulate,
	input logic finish,
	input countValue index,
	input logic [dataWidth-1:0] hiddenValue,
	output logic [dataWidth-1:0] result
);

	localparam int indexBits = $clog2(numHidden);

	logic [dataWidth-1:0] acc;
	logic [dataWidth-1:0] product;

	// Only the low byte of the product is kept.
	always_comb
	begin
		product = dataWidth'(hiddenValue * weights[index[indexBits-1:0]]);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			result <= '0;
		end
		else
		begin
			if (clear)
				acc <= bias;
			else if (accumulate)
				acc <= acc + product;
			if (finish)
				result <= acc[dataWidth-1] ? '0 : acc;
		end
	end

endmodule

// ==== logic/denseNode.sv ====
`timescale 1ns/100ps

module denseNode
	import nnFormatPkg::*;
#(
	parameter logic [0:numInputs-1][dataWidth-1:0] weights = '0,
	parameter logic [dataWidth-1:0] bias = '0
)(
	input logic clk,
	input logic reset,
	input logic signed [dataWidth-1:0] activation0,
	input logic signed [dataWidth-1:0] activation1,
	input logic signed [dataWidth-1:0] activation2,
	input logic signed [dataWidth-1:0] activation3,
	input logic signed [dataWidth-1:0] activation4,
	input logic signed [dataWidth-1:0] activation5,
	input logic signed [dataWidth-1:0] activation6,
	input logic signed [dataWidth-1:0] activation7,
	input logic signed [dataWidth-1:0] activation8,
	input logic signed [dataWidth-1:0] activation9,
	output logic [dataWidth-1:0] hidden
);

	logic [dataWidth-1:0] inputReg [numInputs];
	logic [dataWidth-1:0] sumNext;
	logic [dataWidth-1:0] sumReg;

	// Low byte of each product, so sign handling is not needed.
	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < numInputs; i++)
		begin
			sumNext = sumNext + dataWidth'(inputReg[i] * weights[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				inputReg[i] <= '0;
			end
			sumReg <= '0;
			hidden <= '0;
		end
		else
		begin
			inputReg[0] <= activation0;
			inputReg[1] <= activation1;
			inputReg[2] <= activation2;
			inputReg[3] <= activation3;
			inputReg[4] <= activation4;
			inputReg[5] <= activation5;
			inputReg[6] <= activation6;
			inputReg[7] <= activation7;
			inputReg[8] <= activation8;
			inputReg[9] <= activation9;
			sumReg <= sumNext;
			// ReLU on the wrapped sum.
			hidden <= sumReg[dataWidth-1] ? '0 : sumReg;
		end
	end

endmodule

// ==== logic/nnWeightsPkg.sv ====
package nnWeightsPkg;

	import nnFormatPkg::*;

	// One row per hidden neuron, input 0 first.
	localparam logic [0:numHidden-1][0:numInputs-1][dataWidth-1:0] hiddenWeights =
	'{
		'{8'h87, 8'h90, 8'h0f, 8'h3e, 8'hf6, 8'h43, 8'hba, 8'hd6, 8'h58, 8'hf6},
		'{8'h12, 8'hfd, 8'h21, 8'h07, 8'hc4, 8'h1b, 8'h35, 8'hee, 8'h09, 8'h2c},
		'{8'hf0, 8'h06, 8'h4a, 8'hd9, 8'h13, 8'hfa, 8'h28, 8'h11, 8'hc7, 8'h3b},
		'{8'h05, 8'h39, 8'he2, 8'h1f, 8'h0d, 8'hb8, 8'hf9, 8'h46, 8'h24, 8'h0e}
	};

	localparam logic [0:numHidden-1][dataWidth-1:0] hiddenBias =
	'{
		8'h0b,
		8'hf8,
		8'h14,
		8'h03
	};

	// Hidden neuron 0 first.
	localparam logic [0:numHidden-1][dataWidth-1:0] outputWeights =
	'{
		8'h1d,
		8'hf3,
		8'h27,
		8'h0a
	};

	localparam logic [dataWidth-1:0] outputBias = 8'h05;

endpackage

// ==== logic/nnFormatPkg.sv ====
package nnFormatPkg;

	// Activation and weight width.
	localparam int dataWidth = 8;

	localparam int numInputs = 10;
	localparam int numHidden = 4;

	// Pipeline depth of a dense node.
	localparam int settleCycles = 3;

	typedef enum logic [1:0]
	{
		seqIdle = 2'd0,
		seqSettle = 2'd1,
		seqAccumulate = 2'd2,
		seqFinish = 2'd3
	} seqState;

	// Shared by the step counter and the sequencer.
	typedef logic [2:0] countValue;

endpackage
